// ==== riffa_rx_bridge.f ====
riffa_rx_pkg.sv
tlp_beat_if.sv
tlp_realigner.sv
tlp_beat_fifo.sv
riffa_rx_framer.sv
riffa_rx_bridge.sv
riffa_rx_bridge_checker.sv
riffa_rx_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the riffa_rx_bridge testbench with Verilator.
# The run counts as passed only if the output holds the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module riffa_rx_bridge_tb \
    -f riffa_rx_bridge.f \
    -o sim_riffa_rx_bridge

out=$(./obj_dir/sim_riffa_rx_bridge)
echo "$out"
echo "$out" | grep -q "^Test passed$"

// ==== riffa_rx_bridge_golden.txt ====
# T <back-pressure>   starts a test
# I <last> <tuser> <dword keep> <data>   input beat from the core
# O <last> <sof> <eof> <err> <byte keep> <data>   expected beat to RIFFA
T 0
I 0 00 f 0000100000000000000000ff60000002
I 0 00 f 44444444333333332222222211111111
I 1 00 3 00000000000000006666666655555555
O 0 10 0f 0 ffff 0000100000000000000000ff60000002
O 0 00 0f 0 ffff 44444444333333332222222211111111
O 1 00 17 0 00ff 00000000000000006666666655555555
T 0
I 0 00 f deadbeef00002000000000ff40000008
I 0 00 f a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
I 1 00 f b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0
O 0 10 0f 0 ffff a0a0a0a000002000000000ff40000008
O 0 00 0f 0 ffff b0b0b0b0a3a3a3a3a2a2a2a2a1a1a1a1
O 1 00 1b 0 0fff 00000000b3b3b3b3b2b2b2b2b1b1b1b1
T 0
I 1 00 f cafef00d00003000000000ff4a000001
O 1 10 1b 0 0fff 0000000000003000000000ff4a000001
T 1
I 0 00 f 0000400000000000000000ff60000001
I 1 00 1 000000000000000000000000c1c1c1c1
I 0 00 f ffffffff00005000000000ff40000001
I 1 00 1 000000000000000000000000d1d1d1d1
I 1 00 f 1234567800006000000000ff40000002
I 0 00 f eeeeeeee00007000000000ff40000003
I 1 00 3 0000000000000000e2e2e2e2e1e1e1e1
O 0 10 0f 0 ffff 0000400000000000000000ff60000001
O 1 00 13 0 000f 000000000000000000000000c1c1c1c1
O 1 10 1f 0 ffff d1d1d1d100005000000000ff40000001
O 1 10 1b 0 0fff 0000000000006000000000ff40000002
O 0 10 0f 0 ffff e1e1e1e100007000000000ff40000003
O 1 00 13 0 000f 000000000000000000000000e2e2e2e2
T 0
I 0 00 f 0badbad000008000000000ff40000004
I 0 02 f f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
I 1 00 1 000000000000000000000000f4f4f4f4
O 0 10 0f 0 ffff f0f0f0f000008000000000ff40000004
O 1 00 1f 1 ffff f4f4f4f4f3f3f3f3f2f2f2f2f1f1f1f1

// ==== riffa_rx_bridge_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module riffa_rx_bridge_tb
    import riffa_rx_pkg::*;
();

    localparam int TIMEOUT_CYC = 300;

    typedef struct packed {
        logic              last;
        logic [7:0]        user;
        logic [3:0]        keep;
        logic [DATA_W-1:0] data;
    } in_beat_t;

    typedef struct packed {
        logic              last;
        logic [4:0]        sof;
        logic [4:0]        eof;
        logic              err;
        logic [15:0]       keep;
        logic [DATA_W-1:0] data;
    } out_beat_t;

    logic pclk_div2;
    logic core_rst_n;
    logic [DATA_W-1:0] in_tdata;
    logic [3:0] in_tkeep;
    logic in_tlast;
    logic in_tvalid;
    logic [7:0] in_tuser;
    logic in_tready;
    logic [DATA_W-1:0] rx_tdata;
    logic [15:0] rx_tkeep;
    logic rx_tlast;
    logic rx_tvalid;
    logic rx_tready;
    logic [4:0] sof;
    logic [4:0] eof;
    logic rerr;

    in_beat_t in_q[$];
    out_beat_t exp_q[$];
    logic bp;
    logic [31:0] lcg_state;
    int errors = 0;
    int failed_tests = 0;
    bit aborted = 0;

    riffa_rx_bridge #(.FIFO_DEPTH(4)) dut (
        .pclk_div2(pclk_div2), .core_rst_n(core_rst_n),
        .axis_master_tdata_i(in_tdata), .axis_master_tkeep_i(in_tkeep),
        .axis_master_tlast_i(in_tlast), .axis_master_tvalid_i(in_tvalid),
        .axis_master_tuser_i(in_tuser), .axis_master_tready_o(in_tready),
        .m_axis_rx_tdata_o(rx_tdata), .m_axis_rx_tkeep_o(rx_tkeep),
        .m_axis_rx_tlast_o(rx_tlast), .m_axis_rx_tvalid_o(rx_tvalid),
        .m_axis_rx_tready_i(rx_tready), .is_sof_o(sof), .is_eof_o(eof),
        .rerr_fwd_o(rerr)
    );

    bind riffa_rx_bridge riffa_rx_bridge_checker u_checker (
        .pclk_div2(pclk_div2), .core_rst_n(core_rst_n),
        .out_valid_i(m_axis_rx_tvalid_o), .out_ready_i(m_axis_rx_tready_i),
        .out_last_i(m_axis_rx_tlast_o), .out_data_i(m_axis_rx_tdata_o),
        .is_sof_i(is_sof_o), .in_ready_i(axis_master_tready_o)
    );

    always #4 pclk_div2 = ~pclk_div2;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // drives one test's input beats and checks every beat RIFFA takes
    task automatic run_test(input int num);
        int in_idx;
        int out_idx;
        int cycles;
        int test_errs;
        out_beat_t got;
        in_idx = 0;
        out_idx = 0;
        cycles = 0;
        test_errs = 0;
        while (out_idx < exp_q.size() && cycles < TIMEOUT_CYC) begin
            @(negedge pclk_div2);
            cycles++;
            lcg_state = lcg_next(lcg_state);
            rx_tready = bp ? lcg_state[16] : 1'b1;
            in_tvalid = (in_idx < in_q.size());
            if (in_tvalid) begin
                {in_tlast, in_tuser, in_tkeep, in_tdata} = in_q[in_idx];
            end
            // handshakes that complete on the coming rising edge
            if (in_tvalid && in_tready) begin
                in_idx++;
            end
            if (rx_tvalid && rx_tready) begin
                got = {rx_tlast, sof, eof, rerr, rx_tkeep, rx_tdata};
                assert (got == exp_q[out_idx]) else begin
                    $display("mismatch at %0t: test %0d beat %0d got %h expected %h",
                             $time, num, out_idx, got, exp_q[out_idx]);
                    test_errs++;
                end
                out_idx++;
            end
        end
        if (out_idx < exp_q.size()) begin
            $display("timeout: test %0d delivered only %0d of %0d output beats",
                     num, out_idx, exp_q.size());
            test_errs++;
            aborted = 1;
        end
        $display("test %0d: %0d beats in, %0d beats out, %0d errors",
                 num, in_q.size(), out_idx, test_errs);
        errors += test_errs;
        if (test_errs > 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        int fd;
        int num;
        string line;
        logic f_last;
        logic f_err;
        logic [7:0] f_user;
        logic [3:0] f_keep;
        logic [4:0] f_sof;
        logic [4:0] f_eof;
        logic [15:0] f_bkeep;
        logic [DATA_W-1:0] f_data;
        pclk_div2 = 1'b0;
        core_rst_n = 1'b0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tlast = 1'b0;
        in_tvalid = 1'b0;
        in_tuser = '0;
        rx_tready = 1'b1;
        bp = 1'b0;
        num = 0;
        lcg_state = 32'head4a366;
        repeat (2) @(posedge pclk_div2);
        @(negedge pclk_div2);
        // outputs idle and input ready while in reset
        assert (!rx_tvalid && !rx_tlast && sof == 5'd0 && !rerr && in_tready) else begin
            $display("mismatch at %0t: outputs not in their reset state", $time);
            errors++;
        end
        core_rst_n = 1'b1;
        fd = $fopen("riffa_rx_bridge_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errors++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] == "T") begin
                    if (num > 0) begin
                        run_test(num);
                    end
                    num++;
                    in_q.delete();
                    exp_q.delete();
                    void'($sscanf(line, "T %h", bp));
                end else if (line.len() > 0 && line[0] == "I") begin
                    void'($sscanf(line, "I %h %h %h %h", f_last, f_user, f_keep, f_data));
                    in_q.push_back({f_last, f_user, f_keep, f_data});
                end else if (line.len() > 0 && line[0] == "O") begin
                    void'($sscanf(line, "O %h %h %h %h %h %h",
                                  f_last, f_sof, f_eof, f_err, f_bkeep, f_data));
                    exp_q.push_back({f_last, f_sof, f_eof, f_err, f_bkeep, f_data});
                end
            end
            if (num > 0 && !aborted) begin
                run_test(num);
            end
            $fclose(fd);
        end
        if (num == 0) begin
            $display("no tests found in the golden file");
            errors++;
        end
        $display("%0d tests, %0d failed, %0d errors, %0d checker failures",
                 num, failed_tests, errors, dut.u_checker.fail_cnt);
        if (errors == 0 && dut.u_checker.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== riffa_rx_bridge_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module riffa_rx_bridge_checker (
    input wire         pclk_div2,
    input wire         core_rst_n,
    input wire         out_valid_i,
    input wire         out_ready_i,
    input wire         out_last_i,
    input wire [127:0] out_data_i,
    input wire [4:0]   is_sof_i,
    input wire         in_ready_i
);

    int   fail_cnt = 0;
    logic prev_last;

    // last flag of the beat most recently taken by RIFFA
    always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
        if (!core_rst_n) begin
            prev_last <= 1'b1;
        end else if (out_valid_i && out_ready_i) begin
            prev_last <= out_last_i;
        end
    end

    stall_stable: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
        $error("output beat changed while RIFFA stalled it");
        fail_cnt++;
    end

    ready_after_reset: assert property (@(posedge pclk_div2)
        $rose(core_rst_n) |-> in_ready_i)
    else begin
        $error("input tready low right after reset");
        fail_cnt++;
    end

    // sof only on a beat that opens a new TLP
    sof_after_last: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
        out_valid_i && is_sof_i[4] |-> prev_last)
    else begin
        $error("sof raised inside a TLP");
        fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== riffa_rx_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module riffa_rx_bridge
    import riffa_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                        pclk_div2,
    input  wire                        core_rst_n,

    // from the PCIe core
    input  wire [DATA_W-1:0]           axis_master_tdata_i,
    input  wire [DW_PER_BEAT-1:0]      axis_master_tkeep_i,
    input  wire                        axis_master_tlast_i,
    input  wire                        axis_master_tvalid_i,
    input  wire [7:0]                  axis_master_tuser_i,
    output logic                       axis_master_tready_o,

    // to RIFFA
    output logic [DATA_W-1:0]          m_axis_rx_tdata_o,
    output logic [DW_PER_BEAT*4-1:0]   m_axis_rx_tkeep_o,
    output logic                       m_axis_rx_tlast_o,
    output logic                       m_axis_rx_tvalid_o,
    input  wire                        m_axis_rx_tready_i,
    output logic [4:0]                 is_sof_o,
    output logic [4:0]                 is_eof_o,
    output logic                       rerr_fwd_o
);

    tlp_beat_if rl2ff ();
    tlp_beat_if ff2fr ();

    tlp_realigner u_realigner (
        .pclk_div2            (pclk_div2),
        .core_rst_n           (core_rst_n),
        .axis_master_tdata_i  (axis_master_tdata_i),
        .axis_master_tkeep_i  (axis_master_tkeep_i),
        .axis_master_tlast_i  (axis_master_tlast_i),
        .axis_master_tvalid_i (axis_master_tvalid_i),
        .axis_master_tuser_i  (axis_master_tuser_i),
        .axis_master_tready_o (axis_master_tready_o),
        .beat_o               (rl2ff.source)
    );

    // absorbs RIFFA stalls
    tlp_beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .pclk_div2  (pclk_div2),
        .core_rst_n (core_rst_n),
        .wr         (rl2ff.sink),
        .rd         (ff2fr.source)
    );

    riffa_rx_framer u_framer (
        .pclk_div2          (pclk_div2),
        .core_rst_n         (core_rst_n),
        .beat_i             (ff2fr.sink),
        .m_axis_rx_tdata_o  (m_axis_rx_tdata_o),
        .m_axis_rx_tkeep_o  (m_axis_rx_tkeep_o),
        .m_axis_rx_tlast_o  (m_axis_rx_tlast_o),
        .m_axis_rx_tvalid_o (m_axis_rx_tvalid_o),
        .m_axis_rx_tready_i (m_axis_rx_tready_i),
        .is_sof_o           (is_sof_o),
        .is_eof_o           (is_eof_o),
        .rerr_fwd_o         (rerr_fwd_o)
    );

endmodule

`default_nettype wire

// ==== riffa_rx_framer.sv ====
`timescale 1ns/1ns
`default_nettype none

module riffa_rx_framer
    import riffa_rx_pkg::*;
(
    input  wire                        pclk_div2,
    input  wire                        core_rst_n,

    tlp_beat_if.sink                   beat_i,

    output logic [DATA_W-1:0]          m_axis_rx_tdata_o,
    output logic [DW_PER_BEAT*4-1:0]   m_axis_rx_tkeep_o,
    output logic                       m_axis_rx_tlast_o,
    output logic                       m_axis_rx_tvalid_o,
    input  wire                        m_axis_rx_tready_i,
    output logic [4:0]                 is_sof_o,
    output logic [4:0]                 is_eof_o,
    output logic                       rerr_fwd_o
);

    logic in_pkt;
    logic take;

    // index of the highest valid dword, keep is contiguous from dword 0
    function automatic logic [1:0] last_dw_idx(input logic [DW_PER_BEAT-1:0] keep);
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = 1; i < DW_PER_BEAT; i++) begin
            if (keep[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [DW_PER_BEAT*4-1:0] byte_keep(input logic [DW_PER_BEAT-1:0] keep);
        logic [DW_PER_BEAT*4-1:0] bk;
        for (int i = 0; i < DW_PER_BEAT; i++) begin
            bk[i*4 +: 4] = {4{keep[i]}};
        end
        return bk;
    endfunction

    assign beat_i.ready = !m_axis_rx_tvalid_o || m_axis_rx_tready_i;
    assign take         = beat_i.valid && beat_i.ready;

    always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
        if (!core_rst_n) begin
            m_axis_rx_tvalid_o <= 1'b0;
            m_axis_rx_tlast_o  <= 1'b0;
            is_sof_o           <= 5'd0;
            is_eof_o           <= 5'd0;
            rerr_fwd_o         <= 1'b0;
            in_pkt             <= 1'b0;
        end else if (beat_i.ready) begin
            m_axis_rx_tvalid_o <= beat_i.valid;
            if (take) begin
                m_axis_rx_tlast_o <= beat_i.beat.last;
                // sof on the first beat of each TLP
                is_sof_o   <= {!in_pkt, 4'b0000};
                is_eof_o   <= {beat_i.beat.last, last_dw_idx(beat_i.beat.keep), 2'b11};
                rerr_fwd_o <= beat_i.beat.err & beat_i.beat.last;
                in_pkt     <= !beat_i.beat.last;
            end
        end
    end

    always_ff @(posedge pclk_div2) begin
        if (take) begin
            m_axis_rx_tdata_o <= beat_i.beat.data;
            m_axis_rx_tkeep_o <= byte_keep(beat_i.beat.keep);
        end
    end

endmodule

`default_nettype wire

// ==== tlp_beat_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlp_beat_fifo
    import riffa_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire        pclk_div2,
    input  wire        core_rst_n,

    tlp_beat_if.sink   wr,
    tlp_beat_if.source rd
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    tlp_beat_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr.ready = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign rd.valid = (count != '0);
    assign rd.beat  = mem[rd_ptr];

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    always_ff @(posedge pclk_div2) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr.beat;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
        if (!core_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tlp_realigner.sv ====
`timescale 1ns/1ns
`default_nettype none

module tlp_realigner
    import riffa_rx_pkg::*;
(
    input  wire                    pclk_div2,
    input  wire                    core_rst_n,

    input  wire [DATA_W-1:0]       axis_master_tdata_i,
    input  wire [DW_PER_BEAT-1:0]  axis_master_tkeep_i,
    input  wire                    axis_master_tlast_i,
    input  wire                    axis_master_tvalid_i,
    input  wire [7:0]              axis_master_tuser_i,
    output logic                   axis_master_tready_o,

    tlp_beat_if.source             beat_o
);

    localparam int HOLD_W = DATA_W - 32;

    realign_state_e state;
    realign_state_e state_nxt;

    logic                   out_valid;
    tlp_beat_t              out_beat;
    tlp_beat_t              nxt_beat;
    logic                   out_adv;
    logic                   in_fire;
    logic                   emit;
    logic                   is_4dw;
    logic                   err_acc;
    logic                   err_acc_nxt;
    logic                   err_now;

    // dwords carried over to the next output beat
    logic [HOLD_W-1:0]      hold_data;
    logic [DW_PER_BEAT-2:0] hold_keep;

    assign out_adv              = !out_valid || beat_o.ready;
    assign axis_master_tready_o = (state != RA_FLUSH) && out_adv;
    assign in_fire              = axis_master_tvalid_i && axis_master_tready_o;
    assign is_4dw               = axis_master_tdata_i[FMT_4DW_BIT];
    assign err_now              = err_acc | (|axis_master_tuser_i[ERR_USER_W-1:0]);

    always_comb begin
        state_nxt   = state;
        emit        = 1'b0;
        nxt_beat    = '0;
        err_acc_nxt = err_acc;
        case (state)
            RA_IDLE: begin
                if (in_fire) begin
                    err_acc_nxt = axis_master_tlast_i ? 1'b0 : err_now;
                    if (is_4dw) begin
                        emit          = 1'b1;
                        nxt_beat.data = axis_master_tdata_i;
                        nxt_beat.keep = axis_master_tkeep_i;
                        nxt_beat.last = axis_master_tlast_i;
                        nxt_beat.err  = axis_master_tlast_i & err_now;
                        state_nxt     = axis_master_tlast_i ? RA_IDLE : RA_PASS;
                    end else if (axis_master_tlast_i) begin
                        // header-only 3DW, just drop the pad
                        emit          = 1'b1;
                        nxt_beat.data = {32'h0, axis_master_tdata_i[HOLD_W-1:0]};
                        nxt_beat.keep = axis_master_tkeep_i & 4'b0111;
                        nxt_beat.last = 1'b1;
                        nxt_beat.err  = err_now;
                    end else begin
                        state_nxt = RA_SHIFT;
                    end
                end
            end
            RA_PASS: begin
                if (in_fire) begin
                    emit          = 1'b1;
                    nxt_beat.data = axis_master_tdata_i;
                    nxt_beat.keep = axis_master_tkeep_i;
                    nxt_beat.last = axis_master_tlast_i;
                    nxt_beat.err  = axis_master_tlast_i & err_now;
                    err_acc_nxt   = axis_master_tlast_i ? 1'b0 : err_now;
                    state_nxt     = axis_master_tlast_i ? RA_IDLE : RA_PASS;
                end
            end
            RA_SHIFT: begin
                if (in_fire) begin
                    emit          = 1'b1;
                    nxt_beat.data = {axis_master_tdata_i[31:0], hold_data};
                    nxt_beat.keep = 4'b1111;
                    err_acc_nxt   = err_now;
                    if (axis_master_tlast_i) begin
                        if (axis_master_tkeep_i[1]) begin
                            // dwords 1.. of this beat still to go out
                            state_nxt = RA_FLUSH;
                        end else begin
                            nxt_beat.last = 1'b1;
                            nxt_beat.err  = err_now;
                            err_acc_nxt   = 1'b0;
                            state_nxt     = RA_IDLE;
                        end
                    end
                end
            end
            RA_FLUSH: begin
                if (out_adv) begin
                    emit          = 1'b1;
                    nxt_beat.data = {32'h0, hold_data};
                    nxt_beat.keep = {1'b0, hold_keep};
                    nxt_beat.last = 1'b1;
                    nxt_beat.err  = err_acc;
                    err_acc_nxt   = 1'b0;
                    state_nxt     = RA_IDLE;
                end
            end
            default: begin
                state_nxt = RA_IDLE;
            end
        endcase
    end

    always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
        if (!core_rst_n) begin
            state     <= RA_IDLE;
            out_valid <= 1'b0;
            err_acc   <= 1'b0;
        end else begin
            state   <= state_nxt;
            err_acc <= err_acc_nxt;
            if (out_adv) begin
                out_valid <= emit;
            end
        end
    end

    always_ff @(posedge pclk_div2) begin
        if (emit) begin
            out_beat <= nxt_beat;
        end
        if (in_fire) begin
            // first 3DW beat keeps dwords 0..2, later beats keep 1..3
            if (state == RA_IDLE) begin
                hold_data <= axis_master_tdata_i[HOLD_W-1:0];
            end else begin
                hold_data <= axis_master_tdata_i[DATA_W-1:32];
            end
            hold_keep <= axis_master_tkeep_i[DW_PER_BEAT-1:1];
        end
    end

    assign beat_o.valid = out_valid;
    assign beat_o.beat  = out_beat;

endmodule

`default_nettype wire

// ==== tlp_beat_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface tlp_beat_if
    import riffa_rx_pkg::*;
();

    tlp_beat_t beat;
    logic      valid;
    logic      ready;

    // beat moves on a clock edge with valid and ready both high
    modport source (
        output beat,
        output valid,
        input  ready
    );

    modport sink (
        input  beat,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// ==== riffa_rx_pkg.sv ====
`default_nettype none

package riffa_rx_pkg;

    // beat geometry
    localparam int DATA_W      = 128;
    localparam int DW_PER_BEAT = 4;

    // fmt[0] of the TLP header, set for a 4DW header
    localparam int FMT_4DW_BIT = 29;

    // tuser bits flagging a poisoned or errored TLP
    localparam int ERR_USER_W  = 3;

    // realigner states
    typedef enum logic [1:0] {
        RA_IDLE  = 2'b00,
        RA_PASS  = 2'b01,
        RA_SHIFT = 2'b10,
        RA_FLUSH = 2'b11
    } realign_state_e;

    // one beat between the stages
    // err is only meaningful together with last
    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [DW_PER_BEAT-1:0] keep;
        logic                   last;
        logic                   err;
    } tlp_beat_t;

endpackage

`default_nettype wire
